// ==== sim.f ====
design/fpu_nc_pkg.sv
design/fpu_req_if.sv
design/fpu_op_decoder.sv
design/fpu_issue_buffer.sv
design/fpu_noncomp_unit.sv
design/fpu_nc_top.sv
dv/tb_fpu_nc.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_fpu_nc
FILE_LIST  ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/fpu_nc_tests.txt ====
// op_rm_operandA_operandB_result_status, hex; op 0 minmax 1 sgnj 2 cmp 3 class 4 f2x 5 x2f
// status is NV DZ OF UF NX from bit 4 down, so 10 means invalid
1_0_3f800000_c0000000_bf800000_00
1_1_3f800000_40000000_bf800000_00
1_2_bf800000_c0000000_3f800000_00
1_2_7fc00000_80000000_ffc00000_00
4_0_c0490fdb_12345678_c0490fdb_00
5_0_7f800001_00000000_7f800001_00
0_0_3f800000_40000000_3f800000_00
0_1_3f800000_40000000_40000000_00
0_0_bf800000_c0000000_c0000000_00
0_0_00000000_80000000_80000000_00
0_1_80000000_00000000_00000000_00
0_0_7fc00000_40000000_40000000_00
0_0_7f800001_3f800000_3f800000_10
0_1_7fc00000_7fc00001_7fc00000_00
0_0_7f800001_7fc00000_7fc00000_10
2_0_3f800000_40000000_00000001_00
2_0_40000000_3f800000_00000000_00
2_1_c0000000_bf800000_00000001_00
2_1_80000000_00000000_00000000_00
2_2_80000000_00000000_00000001_00
2_2_7fc00000_7fc00000_00000000_00
2_2_7f800001_3f800000_00000000_10
2_0_7fc00000_3f800000_00000000_10
2_1_3f800000_7f800001_00000000_10
3_0_ff800000_00000000_00000001_00
3_0_bf800000_00000000_00000002_00
3_0_80000001_00000000_00000004_00
3_0_80000000_00000000_00000008_00
3_0_00000000_00000000_00000010_00
3_0_00000001_00000000_00000020_00
3_0_3f800000_00000000_00000040_00
3_0_7f800000_00000000_00000080_00
3_0_7f800001_00000000_00000100_00
3_0_7fc00000_00000000_00000200_00

// ==== dv/tb_fpu_nc.sv ====
/*
 * Testbench for the FP32 non-computational front end.
 * Loads stimulus and expected results from dv/fpu_nc_tests.txt, issues the
 * tests in order with trans_id set to the index modulo 8 and throttles the
 * result port from an LFSR so that the issue buffer stalls.
 * Run from the project root.
 */
module tb_fpu_nc;

    localparam int MAX_TESTS = 64;
    localparam int TEST_W    = 112;  // op, rm, a, b, result, status

    logic                               clk_i;
    logic                               rst_ni;
    logic                               flush_i;
    logic                               valid_i;
    logic                               ready_o;
    fpu_nc_pkg::fu_op_e                 operation_i;
    logic [2:0]                         rm_i;
    logic [fpu_nc_pkg::FLEN-1:0]        operand_a_i;
    logic [fpu_nc_pkg::FLEN-1:0]        operand_b_i;
    logic [fpu_nc_pkg::TAG_W-1:0]       trans_id_i;
    logic                               valid_o;
    logic                               result_ready_i;
    logic [fpu_nc_pkg::FLEN-1:0]        result_o;
    logic [fpu_nc_pkg::TAG_W-1:0]       trans_id_o;
    logic [fpu_nc_pkg::STATUS_W-1:0]    status_o;

    logic [TEST_W-1:0] tests [MAX_TESTS];  // One packed test per entry
    int                num_tests;
    int                issue_count;        // Requests taken on ready_o
    int                result_count;       // Results taken on result_ready_i
    int                cycle_count;        // Cycles since reset release
    logic [15:0]       lfsr;

    fpu_nc_top i_dut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .valid_i        (valid_i),
        .ready_o        (ready_o),
        .operation_i    (operation_i),
        .rm_i           (rm_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .trans_id_i     (trans_id_i),
        .valid_o        (valid_o),
        .result_ready_i (result_ready_i),
        .result_o       (result_o),
        .trans_id_o     (trans_id_o),
        .status_o       (status_o)
    );

    always #5 clk_i = ~clk_i;  // 10 unit period

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic announce_failure();
        $display("TB FAILED");
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        announce_failure();
    endtask

    // --------------------
    // Stimulus
    // --------------------
    // Present the next pending test, idle once all are issued
    task automatic drive_next();
        logic [TEST_W-1:0] entry;
        lfsr           = lfsr_step(lfsr);
        result_ready_i = lfsr[15];  // One LFSR bit per cycle
        if (issue_count < num_tests) begin
            entry       = tests[issue_count];
            valid_i     = 1'b1;
            operation_i = fpu_nc_pkg::fu_op_e'(entry[110:108]);
            rm_i        = entry[106:104];
            operand_a_i = entry[103:72];
            operand_b_i = entry[71:40];
            trans_id_i  = issue_count[fpu_nc_pkg::TAG_W-1:0];  // Index modulo 8
        end else begin
            valid_i = 1'b0;
        end
    endtask

    initial begin : main
        int i;
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        valid_i        = 1'b0;
        operation_i    = fpu_nc_pkg::FSGNJ;
        rm_i           = '0;
        operand_a_i    = '0;
        operand_b_i    = '0;
        trans_id_i     = '0;
        result_ready_i = 1'b0;
        lfsr           = 16'd2021;
        issue_count    = 0;
        result_count   = 0;
        cycle_count    = 0;

        // Unused entries keep an op nibble of f, which ends the table
        for (i = 0; i < MAX_TESTS; i++) begin
            tests[i] = {4'hf, 108'(i)};
        end
        $readmemh("dv/fpu_nc_tests.txt", tests);
        num_tests = 0;
        while (num_tests < MAX_TESTS && tests[num_tests][111:108] != 4'hf) begin
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("No tests found in dv/fpu_nc_tests.txt");
            announce_failure();
            $fatal(1);
        end

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        while (result_count < num_tests) begin
            drive_next();     // Inputs change on the falling edge only
            @(negedge clk_i);
        end

        // Everything issued and nothing left pending
        if (issue_count == num_tests && !valid_o) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("Result still pending after the last expected one");
            announce_failure();
            $fatal(1);
        end
    end

    // --------------------
    // Checking
    // --------------------
    always @(posedge clk_i) begin : monitor
        logic [TEST_W-1:0]            entry;
        logic [fpu_nc_pkg::TAG_W-1:0] exp_tag;

        if (rst_ni) begin
            // Nothing may come out before something went in
            assert (!valid_o || issue_count > 0) else begin
                report_mismatch("valid_o high before any request was accepted");
                $fatal(1);
            end

            if (cycle_count == 0) begin
                assert (ready_o) else begin
                    report_mismatch("ready_o low on the first cycle after reset");
                    $fatal(1);
                end
            end
            cycle_count++;
            if (cycle_count > 20 * num_tests + 50) begin
                $display("Timeout: only %0d of %0d results arrived within %0d cycles",
                         result_count, num_tests, cycle_count);
                announce_failure();
                $fatal(1);
            end

            if (valid_i && ready_o) issue_count++;  // Issue transfer

            if (valid_o && result_ready_i) begin
                entry   = tests[result_count];
                exp_tag = result_count[fpu_nc_pkg::TAG_W-1:0];  // In issue order
                assert (result_o == entry[39:8]) else begin
                    report_mismatch($sformatf("test %0d result %h, expected %h",
                                              result_count, result_o, entry[39:8]));
                    $fatal(1);
                end
                assert (status_o == entry[4:0]) else begin
                    report_mismatch($sformatf("test %0d status %b, expected %b",
                                              result_count, status_o, entry[4:0]));
                    $fatal(1);
                end
                assert (trans_id_o == exp_tag) else begin
                    report_mismatch($sformatf("test %0d trans_id %0d, expected %0d",
                                              result_count, trans_id_o, exp_tag));
                    $fatal(1);
                end
                result_count++;
            end
        end
    end

endmodule

// ==== design/fpu_nc_top.sv ====
/*
 * Top level of the FP32 non-computational front end.
 * Issue side and result side are plain valid/ready ports; inside, the
 * decoder feeds the issue buffer and the buffer feeds the unit.
 */
module fpu_nc_top (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    // Issue side
    input  logic                              valid_i,
    output logic                              ready_o,
    input  fpu_nc_pkg::fu_op_e                operation_i,
    input  logic [2:0]                        rm_i,
    input  logic [fpu_nc_pkg::FLEN-1:0]       operand_a_i,
    input  logic [fpu_nc_pkg::FLEN-1:0]       operand_b_i,
    input  logic [fpu_nc_pkg::TAG_W-1:0]      trans_id_i,
    // Result side
    output logic                              valid_o,
    input  logic                              result_ready_i,
    output logic [fpu_nc_pkg::FLEN-1:0]       result_o,
    output logic [fpu_nc_pkg::TAG_W-1:0]      trans_id_o,
    output logic [fpu_nc_pkg::STATUS_W-1:0]   status_o
);

    fpu_req_if issue_req ();  // Decoder to buffer
    fpu_req_if unit_req ();   // Buffer to unit

    fpu_op_decoder i_decoder (
        .valid_i     (valid_i),
        .operation_i (operation_i),
        .rm_i        (rm_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .trans_id_i  (trans_id_i),
        .req         (issue_req.src),
        .ready_o     (ready_o)
    );

    fpu_issue_buffer i_buffer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .up      (issue_req.dst),
        .down    (unit_req.src)
    );

    fpu_noncomp_unit i_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .req         (unit_req.dst),
        .out_valid_o (valid_o),
        .result_o    (result_o),
        .tag_o       (trans_id_o),
        .status_o    (status_o),
        .out_ready_i (result_ready_i)
    );

endmodule

// ==== design/fpu_noncomp_unit.sv ====
/*
 * Two-stage FP32 non-computational unit.
 * Stage 1 registers the request together with the class of both operands,
 * stage 2 computes sign injection, min/max, compare or classify and holds
 * the tagged result with its status until the consumer takes it.
 */
module fpu_noncomp_unit (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    fpu_req_if.dst                            req,
    output logic                              out_valid_o,
    output logic [fpu_nc_pkg::FLEN-1:0]       result_o,
    output logic [fpu_nc_pkg::TAG_W-1:0]      tag_o,
    output logic [fpu_nc_pkg::STATUS_W-1:0]   status_o,
    input  logic                              out_ready_i
);

    typedef struct packed {
        logic zero;
        logic subnormal;
        logic inf;
        logic qnan;
        logic snan;
    } fp_class_t;

    // Class of one FP32 value from exponent and mantissa
    function automatic fp_class_t classify(input logic [fpu_nc_pkg::FLEN-1:0] x);
        fp_class_t c;
        logic exp_max;
        exp_max     = (x[30:23] == 8'hff);
        c.zero      = (x[30:23] == 8'h00) && (x[22:0] == '0);
        c.subnormal = (x[30:23] == 8'h00) && (x[22:0] != '0);
        c.inf       = exp_max && (x[22:0] == '0);
        c.qnan      = exp_max && x[22];               // Quiet bit set
        c.snan      = exp_max && !x[22] && (x[21:0] != '0);
        return c;
    endfunction

    // Stage 1
    logic                           s1_valid;
    fpu_nc_pkg::unit_op_e           s1_op;
    logic [2:0]                     s1_rm;
    logic [fpu_nc_pkg::FLEN-1:0]    s1_a, s1_b;
    logic [fpu_nc_pkg::TAG_W-1:0]   s1_tag;
    fp_class_t                      s1_cls_a, s1_cls_b;

    logic s1_ready, s2_ready;

    // Stage 2 inputs, computed from stage 1
    logic [fpu_nc_pkg::FLEN-1:0]    res_d;
    logic                           nv_d;

    // --------------------
    // Handshake
    // --------------------
    assign s2_ready  = !out_valid_o || out_ready_i;  // Empty or draining
    assign s1_ready  = !s1_valid || s2_ready;        // Stage 1 can advance
    assign req.ready = s1_ready;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid    <= 1'b0;
            out_valid_o <= 1'b0;
        end else if (flush_i) begin
            s1_valid    <= 1'b0;  // In-flight requests are dropped
            out_valid_o <= 1'b0;
        end else begin
            if (s1_ready) s1_valid <= req.valid;
            if (s2_ready) out_valid_o <= s1_valid;
        end
    end

    // Stage 1 payload with operand classes
    always_ff @(posedge clk_i) begin
        if (req.valid && s1_ready) begin
            s1_op     <= req.op;
            s1_rm     <= req.rm;
            s1_a      <= req.operand_a;
            s1_b      <= req.operand_b;
            s1_tag    <= req.tag;
            s1_cls_a  <= classify(req.operand_a);
            s1_cls_b  <= classify(req.operand_b);
        end
    end

    // --------------------
    // Stage 2 datapath
    // --------------------
    always_comb begin : compute
        logic nan_a, nan_b, any_snan, both_zero, a_lt_b, cmp_bit;
        nan_a     = s1_cls_a.qnan || s1_cls_a.snan;
        nan_b     = s1_cls_b.qnan || s1_cls_b.snan;
        any_snan  = s1_cls_a.snan || s1_cls_b.snan;
        both_zero = s1_cls_a.zero && s1_cls_b.zero;
        // Total order with -0 below +0, magnitudes flip for negatives
        if (s1_a[31] != s1_b[31]) a_lt_b = s1_a[31];
        else if (s1_a[31])        a_lt_b = s1_a[30:0] > s1_b[30:0];
        else                      a_lt_b = s1_a[30:0] < s1_b[30:0];
        cmp_bit = 1'b0;
        res_d   = s1_a;
        nv_d    = 1'b0;

        unique case (s1_op)
            fpu_nc_pkg::SGNJ: begin
                case (s1_rm)
                    3'b000:  res_d = {s1_b[31], s1_a[30:0]};             // sgnj
                    3'b001:  res_d = {~s1_b[31], s1_a[30:0]};            // sgnjn
                    3'b010:  res_d = {s1_a[31] ^ s1_b[31], s1_a[30:0]};  // sgnjx
                    default: res_d = s1_a;                               // Raw move
                endcase
            end
            fpu_nc_pkg::MINMAX: begin
                nv_d = any_snan;
                if (nan_a && nan_b) res_d = fpu_nc_pkg::QNAN_CANON;
                else if (nan_a)     res_d = s1_b;  // A NaN loses to a number
                else if (nan_b)     res_d = s1_a;
                else                res_d = (a_lt_b ^ s1_rm[0]) ? s1_a : s1_b;
            end
            fpu_nc_pkg::CMP: begin
                // Signed zeros compare equal here
                case (s1_rm[1:0])
                    2'b00: begin
                        cmp_bit = (a_lt_b && !both_zero) || (s1_a == s1_b) || both_zero;
                        nv_d    = nan_a || nan_b;  // le signals on any NaN
                    end
                    2'b01: begin
                        cmp_bit = a_lt_b && !both_zero;
                        nv_d    = nan_a || nan_b;
                    end
                    default: begin
                        cmp_bit = (s1_a == s1_b) || both_zero;
                        nv_d    = any_snan;        // eq is quiet
                    end
                endcase
                if (nan_a || nan_b) cmp_bit = 1'b0;
                res_d = {31'b0, cmp_bit};
            end
            default: begin  // CLASSIFY, one-hot class of operand a
                res_d = {22'b0,
                         s1_cls_a.qnan,
                         s1_cls_a.snan,
                         !s1_a[31] && s1_cls_a.inf,
                         !s1_a[31] && (s1_a[30:23] != 8'h00) && (s1_a[30:23] != 8'hff),
                         !s1_a[31] && s1_cls_a.subnormal,
                         !s1_a[31] && s1_cls_a.zero,
                         s1_a[31] && s1_cls_a.zero,
                         s1_a[31] && s1_cls_a.subnormal,
                         s1_a[31] && (s1_a[30:23] != 8'h00) && (s1_a[30:23] != 8'hff),
                         s1_a[31] && s1_cls_a.inf};
            end
        endcase
    end

    // Stage 2 output register, held under back-pressure
    always_ff @(posedge clk_i) begin
        if (s1_valid && s2_ready) begin
            result_o <= res_d;
            tag_o    <= s1_tag;
            status_o <= '0;
            status_o[fpu_nc_pkg::STATUS_NV] <= nv_d;
        end
    end

    // A stalled result must not move until the consumer accepts it
    result_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_o && !out_ready_i && !flush_i |=>
            out_valid_o && $stable({result_o, tag_o, status_o}))
        else $error("result changed while stalled");

endmodule

// ==== design/fpu_issue_buffer.sv ====
/*
 * Issue hold buffer between decoder and unit.
 * Upstream sees ready high until a request is actually refused; the
 * refused request is captured and replayed to the unit from the hold
 * register while upstream is stalled.
 */
module fpu_issue_buffer (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    flush_i,
    fpu_req_if.dst  up,
    fpu_req_if.src  down
);

    typedef enum logic {
        READY,
        STALL
    } state_e;

    state_e state_q, state_d;

    logic hold;      // Capture the live request
    logic use_hold;  // Present the held request downstream

    // Hold register for the whole request
    fpu_nc_pkg::unit_op_e               op_q;
    logic                               op_mod_q;
    logic [2:0]                         rm_q;
    logic [fpu_nc_pkg::FLEN-1:0]        operand_a_q;
    logic [fpu_nc_pkg::FLEN-1:0]        operand_b_q;
    logic [fpu_nc_pkg::TAG_W-1:0]       tag_q;

    // --------------------
    // Handshake FSM
    // --------------------
    always_comb begin : issue_fsm
        up.ready   = 1'b0;
        down.valid = 1'b0;
        hold       = 1'b0;
        use_hold   = 1'b0;
        state_d    = state_q;

        unique case (state_q)
            READY: begin
                up.ready   = 1'b1;      // Optimistic ready towards issue
                down.valid = up.valid;  // Straight through
                if (up.valid && !down.ready) begin
                    up.ready = 1'b0;    // Refused, take it back
                    hold     = 1'b1;
                    state_d  = STALL;
                end
            end
            STALL: begin
                down.valid = 1'b1;
                use_hold   = 1'b1;
                if (down.ready) begin
                    up.ready = 1'b1;  // Held request leaves, upstream transfer completes
                    state_d  = READY;
                end
            end
            default: ;
        endcase

        if (flush_i) begin
            state_d = READY;  // Held request is dropped
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (hold) begin
            op_q        <= up.op;
            op_mod_q    <= up.op_mod;
            rm_q        <= up.rm;
            operand_a_q <= up.operand_a;
            operand_b_q <= up.operand_b;
            tag_q       <= up.tag;
        end
    end

    // Held or live request towards the unit
    assign down.op        = use_hold ? op_q        : up.op;
    assign down.op_mod    = use_hold ? op_mod_q    : up.op_mod;
    assign down.rm        = use_hold ? rm_q        : up.rm;
    assign down.operand_a = use_hold ? operand_a_q : up.operand_a;
    assign down.operand_b = use_hold ? operand_b_q : up.operand_b;
    assign down.tag       = use_hold ? tag_q       : up.tag;

    // A refused request keeps being offered unchanged until the unit takes it
    stall_holds_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
        down.valid && !down.ready && !flush_i |=>
            down.valid && $stable({down.op, down.op_mod, down.rm, down.operand_a,
                                   down.operand_b, down.tag}))
        else $error("issue buffer lost or changed a held request");

endmodule

// ==== design/fpu_op_decoder.sv ====
/*
 * Instruction decoder for the non-computational FPU path.
 * Maps the issued operation and its rm field onto a unit request.
 * Purely combinational; ready from the request link is sent back upstream.
 */
module fpu_op_decoder (
    input  logic                          valid_i,
    input  fpu_nc_pkg::fu_op_e            operation_i,
    input  logic [2:0]                    rm_i,
    input  logic [fpu_nc_pkg::FLEN-1:0]   operand_a_i,
    input  logic [fpu_nc_pkg::FLEN-1:0]   operand_b_i,
    input  logic [fpu_nc_pkg::TAG_W-1:0]  trans_id_i,
    fpu_req_if.src                        req,
    output logic                          ready_o
);

    // Payload that needs no translation
    assign req.valid     = valid_i;
    assign req.operand_a = operand_a_i;
    assign req.operand_b = operand_b_i;
    assign req.tag       = trans_id_i;

    // Handshake back to issue
    assign ready_o = req.ready;

    // --------------------
    // Operation mapping
    // --------------------
    always_comb begin : op_translate
        // Defaults: raw move of operand a
        req.op     = fpu_nc_pkg::SGNJ;
        req.op_mod = 1'b0;
        req.rm     = 3'b011;

        unique case (operation_i)
            fpu_nc_pkg::FSGNJ: begin
                req.op = fpu_nc_pkg::SGNJ;
                req.rm = {1'b0, rm_i[1:0]};  // Bit 2 is not part of the encoding
            end
            fpu_nc_pkg::FMIN_MAX: begin
                req.op = fpu_nc_pkg::MINMAX;
                req.rm = {1'b0, rm_i[1:0]};  // 000 min, 001 max
            end
            fpu_nc_pkg::FCMP: begin
                req.op = fpu_nc_pkg::CMP;
                req.rm = {1'b0, rm_i[1:0]};  // 000 le, 001 lt, 010 eq
            end
            fpu_nc_pkg::FCLASS: begin
                req.op = fpu_nc_pkg::CLASSIFY;
                req.rm = {1'b0, rm_i[1:0]};  // Ignored by the unit
            end
            // Moves have no recoding, passthrough of operand a
            fpu_nc_pkg::FMV_F2X: begin
                req.op     = fpu_nc_pkg::SGNJ;
                req.rm     = 3'b011;
                req.op_mod = 1'b1;  // Result heads for the integer side
            end
            fpu_nc_pkg::FMV_X2F: begin
                req.op = fpu_nc_pkg::SGNJ;
                req.rm = 3'b011;
            end
            default: ;  // Unknown codes keep the passthrough
        endcase
    end

endmodule

// ==== design/fpu_req_if.sv ====
/*
 * One request into the non-computational unit with its valid/ready pair.
 * The source holds the payload stable from valid until the transfer,
 * which happens on a rising edge where valid and ready are both high.
 */
interface fpu_req_if;

    logic                               valid;
    logic                               ready;
    fpu_nc_pkg::unit_op_e               op;
    logic                               op_mod;     // Operation modifier
    logic [2:0]                         rm;         // Sub-operation select
    logic [fpu_nc_pkg::FLEN-1:0]        operand_a;
    logic [fpu_nc_pkg::FLEN-1:0]        operand_b;
    logic [fpu_nc_pkg::TAG_W-1:0]       tag;

    // Request producer
    modport src (
        output valid, op, op_mod, rm, operand_a, operand_b, tag,
        input  ready
    );

    // Request consumer
    modport dst (
        input  valid, op, op_mod, rm, operand_a, operand_b, tag,
        output ready
    );

endinterface

// ==== design/fpu_nc_pkg.sv ====
/*
 * Shared definitions for the FP32 non-computational front end.
 * Holds the data widths, the issued and unit-level operation codes and
 * the position of the invalid flag in the status vector.
 * Files refer to these items as fpu_nc_pkg::name.
 */
package fpu_nc_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int unsigned FLEN     = 32;  // FP32 operands and results
    localparam int unsigned TAG_W    = 3;   // Transaction id carried with each request
    localparam int unsigned STATUS_W = 5;   // NV DZ OF UF NX, MSB first

    // Invalid operation flag, the only one this unit can raise
    localparam int unsigned STATUS_NV = 4;

    // Canonical quiet NaN returned when min/max sees two NaNs
    localparam logic [FLEN-1:0] QNAN_CANON = 32'h7fc0_0000;

    // --------------------
    // Operations
    // --------------------

    // Operations as issued to the FPU
    typedef enum logic [2:0] {
        FMIN_MAX = 3'd0,  // Min or max, selected by rm
        FSGNJ    = 3'd1,  // Sign injection, variant in rm
        FCMP     = 3'd2,  // le, lt or eq in rm
        FCLASS   = 3'd3,  // Classify operand a
        FMV_F2X  = 3'd4,  // FP register to integer register
        FMV_X2F  = 3'd5   // Integer register to FP register
    } fu_op_e;

    // Operations seen by the unit after decode
    typedef enum logic [1:0] {
        SGNJ     = 2'd0,
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } unit_op_e;

endpackage
